//--- Bender.yml
package:
  name: zx_ula

sources:
  - rtl/zx_ula_pkg.sv
  - rtl/zx_clock_enables.sv
  - rtl/zx_sync_control.sv
  - rtl/zx_display_timing.sv
  - rtl/zx_memory_map.sv
  - rtl/zx_ula_top.sv
  - target: simulation
    files:
      - sim/zx_ula_checker.sv
      - sim/tb_zx_ula.sv

//--- rtl/zx_clock_enables.sv
/*
 * Clock enables from clk_sys. All outputs are one-cycle pulses.
 * Pixel rate is clk_sys/8, sync and CPU rates clk_sys/16.
 */
`timescale 1ns/10ps
`default_nettype none

module zx_clock_enables (
	input  logic clk_sys,
	input  logic reset,
	output logic ce_cpu_p,
	output logic ce_cpu_n,
	output logic ce_pix,
	output logic ce_sync
);

	logic [3:0] count;

	// Free-running divider
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			count <= 4'd0;
		end else begin
			count <= count + 4'd1;
		end
	end

	// Registered pulses at fixed phases of the count
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			ce_cpu_p <= 1'b0;
			ce_cpu_n <= 1'b0;
			ce_pix   <= 1'b0;
			ce_sync  <= 1'b0;
		end else begin
			// CPU edges half a period apart
			ce_cpu_p <= (count == 4'd0);
			ce_cpu_n <= (count == 4'd8);
			// Pixel at twice the sync rate
			ce_pix   <= (count[2:0] == 3'd0);
			ce_sync  <= (count == 4'd0);
		end
	end

endmodule

`default_nettype wire

//--- rtl/zx_display_timing.sv
/*
 * Fixed-period display line with hsync and blanking, re-locked to the
 * bus-driven vertical sync. hsync and vsync are sampled on ce_pix only.
 */
`timescale 1ns/10ps
`default_nettype none

module zx_display_timing import zx_ula_pkg::*; #(
	parameter int LINE_TICKS = DISP_LINE_TICKS
) (
	input  logic clk_sys,
	input  logic reset,
	input  logic ce_pix,
	input  logic hsync,
	input  logic vsync,
	output logic disp_hsync,
	output logic disp_vsync,
	output logic hblank,
	output logic vblank
);

	localparam int CNT_W = $clog2(LINE_TICKS);

	logic [CNT_W-1:0] disp_count;
	logic [4:0]       vs_hist;
	logic             hsync_q;
	logic             hsync_rise;

	assign hsync_rise = hsync & ~hsync_q;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			disp_count <= '0;
			disp_hsync <= 1'b0;
			disp_vsync <= 1'b0;
			hblank     <= 1'b0;
			vblank     <= 1'b0;
			vs_hist    <= 5'd0;
			hsync_q    <= 1'b0;
		end else if (ce_pix) begin
			// Free-running line counter
			if (disp_count == CNT_W'(LINE_TICKS - 1)) begin
				disp_count <= '0;
			end else begin
				disp_count <= disp_count + 1'b1;
			end

			if (disp_count == '0) begin
				disp_hsync <= 1'b1;
			end
			if (disp_count == CNT_W'(DISP_HSYNC_END)) begin
				disp_hsync <= 1'b0;
			end

			if (disp_count == CNT_W'(HBLANK_ON)) begin
				hblank <= 1'b1;
			end
			if (disp_count == CNT_W'(HBLANK_OFF)) begin
				hblank <= 1'b0;
			end

			// Vertical sync history, one entry per bus line
			hsync_q <= hsync;
			if (hsync_rise) begin
				vs_hist    <= {vs_hist[3:0], vsync};
				vblank     <= |{vs_hist, vsync};
				disp_vsync <= vs_hist[2];
				// Re-lock the line once vsync has held for two lines
				if (&vs_hist[3:2]) begin
					disp_count <= '0;
				end
			end
		end
	end

endmodule

`default_nettype wire

//--- rtl/zx_memory_map.sv
/*
 * ROM/RAM select and mapped address, decoded combinationally from the bus.
 * Model and RAM size are sampled only while reset is high; a change needs
 * a reset to take effect. ROM has priority over RAM.
 */
`timescale 1ns/10ps
`default_nettype none

module zx_memory_map import zx_ula_pkg::*; (
	input  logic        clk_sys,
	input  logic        reset,
	input  zx_addr_u    addr,
	input  logic        mreq_n,
	input  logic        m1_n,
	input  logic        model_zx80,
	input  logic [1:0]  ram_size,
	input  logic        low_ram,
	output logic        zx81_mode,
	output logic [1:0]  mem_sel,
	output logic [13:0] rom_addr,
	output logic [15:0] ram_addr
);

	// Internal size code is the ram_size code plus one
	localparam logic [1:0] SIZE_1K  = RAM_1K + 2'd1;
	localparam logic [1:0] SIZE_16K = RAM_16K + 2'd1;
	localparam logic [1:0] SIZE_32K = RAM_32K + 2'd1;

	logic [1:0]  size_code;
	logic        a15;
	logic        a14;
	logic [13:0] low14;
	logic        low16k;
	logic        ram_lo;
	logic        ram_hi;
	logic        rom_en;
	logic        ram_en;

	// ========================================================================
	// Configuration latch
	// ========================================================================

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			zx81_mode <= ~model_zx80;
			size_code <= ram_size + 2'd1;
		end
	end

	// ========================================================================
	// Select decode
	// ========================================================================

	assign a15   = addr.mem.region[1];
	assign a14   = addr.mem.region[0];
	assign low14 = {addr.mem.page, addr.mem.bank_bit, addr.mem.offset};

	// Bottom 32K unless the size maps RAM above 8000
	assign low16k = ~a15 | ~size_code[1];
	// 8K window at 2000
	assign ram_lo = ~a14 & addr.mem.page & low16k;
	// Upper RAM for 32K and 48K
	// An M1 fetch at C000 with 48K sees the mirror instead
	assign ram_hi = a15 & size_code[1] & (~a14 | (m1_n & size_code[0]));

	// ZX80 ROM is 4K, ZX81 ROM 8K
	assign rom_en = ~a14 & ~addr.mem.page & (~addr.mem.bank_bit | zx81_mode) & low16k;
	assign ram_en = a14 | ram_hi | (ram_lo & low_ram);

	always_comb begin
		if (mreq_n) begin
			mem_sel = SEL_NONE;
		end else if (rom_en) begin
			mem_sel = SEL_ROM;
		end else if (ram_en) begin
			mem_sel = SEL_RAM;
		end else begin
			mem_sel = SEL_NONE;
		end
	end

	// ========================================================================
	// Mapped addresses
	// ========================================================================

	// ZX80 image sits at 2000 in the ROM array
	assign rom_addr = zx81_mode ? {1'b0, addr.mem.bank_bit, addr.mem.offset}
		: {2'b10, addr.mem.offset};

	always_comb begin
		if (ram_lo) begin
			ram_addr = {3'b001, addr.mem.bank_bit, addr.mem.offset};
		end else if (size_code == SIZE_1K) begin
			ram_addr = {6'b010000, addr.mem.offset[9:0]};
		end else if (size_code == SIZE_16K || !a15
			|| (size_code == SIZE_32K && a14)) begin
			// Main 16K and its C000 mirror for 32K
			ram_addr = {2'b01, low14};
		end else if (!a14) begin
			// Data 16K at 8000
			ram_addr = {2'b10, low14};
		end else begin
			// 48K at C000
			ram_addr = {m1_n, 1'b1, low14};
		end
	end

endmodule

`default_nettype wire

//--- rtl/zx_sync_control.sv
/*
 * Line sync, NMI latch and vertical sync, all driven by Z80 bus cycles.
 * Strobes are sampled every clk_sys cycle; the bus must hold them for at
 * least one cycle. The NMI latch only moves in ZX81 mode.
 */
`timescale 1ns/10ps
`default_nettype none

module zx_sync_control import zx_ula_pkg::*; #(
	parameter int LINE_TICKS = SYNC_LINE_TICKS
) (
	input  logic     clk_sys,
	input  logic     reset,
	input  logic     ce_sync,
	input  zx_addr_u addr,
	input  logic     iorq_n,
	input  logic     rd_n,
	input  logic     wr_n,
	input  logic     m1_n,
	input  logic     halt_n,
	input  logic     zx81_mode,
	output logic     hsync,
	output logic     nmi_n,
	output logic     wait_n,
	output logic     vsync
);

	localparam int CNT_W = $clog2(LINE_TICKS);

	logic [CNT_W-1:0] sync_count;
	logic             nmi_latch;
	logic             vs;
	logic             int_ack;
	logic             io_write;
	logic             kbd_read;
	logic             nmi_port;

	// ========================================================================
	// Bus cycle decode
	// ========================================================================

	assign int_ack  = ~m1_n & ~iorq_n;
	assign io_write = ~iorq_n & ~wr_n;
	assign kbd_read = ~iorq_n & ~rd_n & ~addr.io.port_lo;
	// Exactly one of the two low bits selects an NMI port
	assign nmi_port = addr.io.port_lo ^ addr.io.nmi_off;

	// ========================================================================
	// Line sync counter
	// ========================================================================

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			sync_count <= '0;
			hsync      <= 1'b0;
		end else if (int_ack) begin
			// Interrupt acknowledge restarts the line
			sync_count <= '0;
			hsync      <= 1'b0;
		end else if (ce_sync) begin
			if (sync_count == CNT_W'(LINE_TICKS - 1)) begin
				sync_count <= '0;
			end else begin
				sync_count <= sync_count + 1'b1;
			end
			if (sync_count == CNT_W'(HSYNC_ON_TICK)) begin
				hsync <= 1'b1;
			end
			if (sync_count == CNT_W'(HSYNC_OFF_TICK)) begin
				hsync <= 1'b0;
			end
		end
	end

	// ========================================================================
	// NMI generator and vertical sync
	// ========================================================================

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			nmi_latch <= 1'b0;
		end else if (!zx81_mode) begin
			nmi_latch <= 1'b0;
		end else if (io_write && nmi_port) begin
			nmi_latch <= ~addr.io.nmi_off;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			vs    <= 1'b0;
			vsync <= 1'b0;
		end else begin
			// Keyboard read wins over a write in the same cycle
			if (kbd_read && !nmi_latch) begin
				vs <= 1'b1;
			end else if (io_write && !nmi_latch) begin
				vs <= 1'b0;
			end
			// Only follow vs outside of line sync
			if (!hsync) begin
				vsync <= vs;
			end
		end
	end

	assign nmi_n  = ~(nmi_latch & hsync);
	assign wait_n = halt_n | nmi_n;

endmodule

`default_nettype wire

//--- rtl/zx_ula_pkg.sv
/*
 * Shared timing constants, select codes and bus address views for the ULA.
 * Tick counts assume the clock-enable rates of zx_clock_enables.
 */
`default_nettype none

package zx_ula_pkg;

	// ========================================================================
	// Line timing
	// ========================================================================

	// Bus-driven line, counted in ce_sync ticks
	localparam int SYNC_LINE_TICKS = 207;
	localparam int HSYNC_ON_TICK   = 15;
	localparam int HSYNC_OFF_TICK  = 31;

	// Regenerated display line, counted in ce_pix ticks
	localparam int DISP_LINE_TICKS = 414;
	localparam int DISP_HSYNC_END  = 32;
	localparam int HBLANK_ON       = 400;
	localparam int HBLANK_OFF      = 72;

	// ========================================================================
	// Memory select and RAM size codes
	// ========================================================================

	localparam logic [1:0] SEL_NONE = 2'd0;
	localparam logic [1:0] SEL_ROM  = 2'd1;
	localparam logic [1:0] SEL_RAM  = 2'd2;

	localparam logic [1:0] RAM_16K = 2'd0;
	localparam logic [1:0] RAM_32K = 2'd1;
	localparam logic [1:0] RAM_48K = 2'd2;
	localparam logic [1:0] RAM_1K  = 2'd3;

	// Memory cycles decode 16K regions, port cycles only the low two bits
	typedef struct packed {
		logic [1:0]  region;
		logic        page;
		logic        bank_bit;
		logic [11:0] offset;
	} zx_mem_view_t;

	typedef struct packed {
		logic [13:0] upper;
		logic        nmi_off;
		logic        port_lo;  // low on a keyboard read
	} zx_io_view_t;

	typedef union packed {
		zx_mem_view_t mem;
		zx_io_view_t  io;
	} zx_addr_u;

endpackage

`default_nettype wire

//--- rtl/zx_ula_top.sv
/*
 * ZX80/ZX81 ULA timing and memory map beside an external Z80 bus.
 * Line lengths are in ce_sync and ce_pix ticks. wait_n is reported only.
 */
`timescale 1ns/10ps
`default_nettype none

module zx_ula_top import zx_ula_pkg::*; #(
	parameter int SYNC_LINE_TICKS = zx_ula_pkg::SYNC_LINE_TICKS,
	parameter int DISP_LINE_TICKS = zx_ula_pkg::DISP_LINE_TICKS
) (
	input  logic        clk_sys,
	input  logic        reset,
	input  logic [15:0] addr,
	input  logic        mreq_n,
	input  logic        iorq_n,
	input  logic        rd_n,
	input  logic        wr_n,
	input  logic        m1_n,
	input  logic        halt_n,
	input  logic        model_zx80,
	input  logic [1:0]  ram_size,
	input  logic        low_ram,
	output logic        ce_cpu_p,
	output logic        ce_cpu_n,
	output logic        ce_pix,
	output logic        nmi_n,
	output logic        wait_n,
	output logic [1:0]  mem_sel,
	output logic [13:0] rom_addr,
	output logic [15:0] ram_addr,
	output logic        disp_hsync,
	output logic        disp_vsync,
	output logic        hblank,
	output logic        vblank
);

	logic ce_sync;
	logic hsync;
	logic vsync;
	logic zx81_mode;

	zx_clock_enables clock_enables_i (
		.clk_sys  (clk_sys),
		.reset    (reset),
		.ce_cpu_p (ce_cpu_p),
		.ce_cpu_n (ce_cpu_n),
		.ce_pix   (ce_pix),
		.ce_sync  (ce_sync)
	);

	zx_sync_control #(
		.LINE_TICKS (SYNC_LINE_TICKS)
	) sync_control_i (
		.clk_sys   (clk_sys),
		.reset     (reset),
		.ce_sync   (ce_sync),
		.addr      (zx_addr_u'(addr)),
		.iorq_n    (iorq_n),
		.rd_n      (rd_n),
		.wr_n      (wr_n),
		.m1_n      (m1_n),
		.halt_n    (halt_n),
		.zx81_mode (zx81_mode),
		.hsync     (hsync),
		.nmi_n     (nmi_n),
		.wait_n    (wait_n),
		.vsync     (vsync)
	);

	zx_display_timing #(
		.LINE_TICKS (DISP_LINE_TICKS)
	) display_timing_i (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.ce_pix     (ce_pix),
		.hsync      (hsync),
		.vsync      (vsync),
		.disp_hsync (disp_hsync),
		.disp_vsync (disp_vsync),
		.hblank     (hblank),
		.vblank     (vblank)
	);

	zx_memory_map memory_map_i (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.addr       (zx_addr_u'(addr)),
		.mreq_n     (mreq_n),
		.m1_n       (m1_n),
		.model_zx80 (model_zx80),
		.ram_size   (ram_size),
		.low_ram    (low_ram),
		.zx81_mode  (zx81_mode),
		.mem_sel    (mem_sel),
		.rom_addr   (rom_addr),
		.ram_addr   (ram_addr)
	);

endmodule

`default_nettype wire

//--- sim/tb_zx_ula.sv
/*
 * Testbench for zx_ula_top. Acts as the Z80 bus and sequences five tests;
 * all comparing is done in zx_ula_checker.
 */
`timescale 1ns/10ps
`default_nettype none

module tb_zx_ula;

	localparam int CLK_PERIOD = 20;
	localparam int LINE_CYC   = 3312;
	// Roughly 20 bus lines of tests plus margin
	localparam int RUN_CYCLES = 30 * LINE_CYC;

	logic        clk_sys;
	logic        reset;
	logic [15:0] addr;
	logic        mreq_n, iorq_n, rd_n, wr_n, m1_n, halt_n;
	logic        model_zx80;
	logic [1:0]  ram_size;
	logic        low_ram;
	logic        ce_cpu_p, ce_cpu_n, ce_pix, nmi_n, wait_n;
	logic [1:0]  mem_sel;
	logic [13:0] rom_addr;
	logic [15:0] ram_addr;
	logic        disp_hsync, disp_vsync, hblank, vblank;
	int          test_id;
	int          check_count;
	int          error_count;
	int          seed;

	zx_ula_top dut_i (.*);

	zx_ula_checker checker_i (.*);

	initial begin
		clk_sys = 1'b0;
		forever #(CLK_PERIOD / 2) clk_sys = ~clk_sys;
	end

	task automatic idle_cycles(input int n, input logic rand_halt);
		repeat (n) begin
			@(negedge clk_sys);
			addr   = $random(seed);
			halt_n = rand_halt ? $random(seed) : 1'b1;
		end
	endtask

	task automatic io_cycle(input logic [15:0] a, input logic rd, input logic wr);
		@(negedge clk_sys);
		addr   = a;
		iorq_n = 1'b0;
		rd_n   = ~rd;
		wr_n   = ~wr;
		@(negedge clk_sys);
		{iorq_n, rd_n, wr_n} = 3'b111;
	endtask

	task automatic int_ack();
		@(negedge clk_sys);
		{m1_n, iorq_n} = 2'b00;
		@(negedge clk_sys);
		{m1_n, iorq_n} = 2'b11;
	endtask

	task automatic configure(input logic zx80, input logic [1:0] size, input logic lr);
		@(negedge clk_sys);
		{model_zx80, ram_size, low_ram} = {zx80, size, lr};
		reset = 1'b1;
		repeat (8) @(negedge clk_sys);
		reset = 1'b0;
	endtask

	initial begin
		seed = 89493;
		test_id = 0;
		reset = 1'b1;
		addr = 16'h0000;
		{mreq_n, iorq_n, rd_n, wr_n, m1_n, halt_n} = 6'b111111;
		{model_zx80, ram_size, low_ram} = 4'b0000;

		test_id = 1;
		configure(1'b0, 2'd0, 1'b0);
		idle_cycles(64, 1'b0);

		test_id = 2;
		io_cycle(16'hFF01, 1'b0, 1'b1);
		idle_cycles(2 * LINE_CYC, 1'b1);

		test_id = 3;
		io_cycle(16'hFF02, 1'b0, 1'b1);
		idle_cycles(LINE_CYC, 1'b0);
		io_cycle(16'hFF01, 1'b0, 1'b1);
		while (nmi_n) @(negedge clk_sys);
		idle_cycles(3, 1'b0);
		int_ack();
		idle_cycles(LINE_CYC, 1'b0);
		configure(1'b1, 2'd0, 1'b0);
		io_cycle(16'hFF01, 1'b0, 1'b1);
		idle_cycles(LINE_CYC, 1'b0);
		io_cycle(16'hFF02, 1'b0, 1'b1);
		idle_cycles(LINE_CYC, 1'b0);

		test_id = 4;
		for (int cfg = 0; cfg < 16; cfg++) begin
			configure(cfg[3], cfg[2:1], cfg[0]);
			repeat (200) begin
				@(negedge clk_sys);
				addr   = $random(seed);
				m1_n   = $random(seed);
				mreq_n = $random(seed);
			end
		end
		{mreq_n, m1_n} = 2'b11;

		test_id = 5;
		configure(1'b0, 2'd0, 1'b0);
		io_cycle(16'hFFFE, 1'b1, 1'b0);
		idle_cycles(6 * LINE_CYC, 1'b0);
		io_cycle(16'hFFFF, 1'b0, 1'b1);
		idle_cycles(6 * LINE_CYC, 1'b0);

		test_id = 0;
		repeat (2) @(negedge clk_sys);
		$display("Checks: %0d, errors: %0d", check_count, error_count);
		if (error_count == 0) begin
			$display("Test OK");
		end else begin
			$display("Test FAILED");
		end
		$finish;
	end

	// Watchdog
	initial begin
		#(RUN_CYCLES * CLK_PERIOD);
		$display("Simulation did not finish in time, watchdog expired");
		$display("Test FAILED");
		$finish;
	end

endmodule

`default_nettype wire

//--- sim/zx_ula_checker.sv
/*
 * Cycle model of the ULA that watches the DUT ports and compares outputs.
 * Outputs are sampled on the rising edge, while the inputs are stable.
 */
`timescale 1ns/10ps
`default_nettype none

module zx_ula_checker import zx_ula_pkg::*; (
	input  logic        clk_sys,
	input  logic        reset,
	input  int          test_id,
	input  logic [15:0] addr,
	input  logic        mreq_n,
	input  logic        iorq_n,
	input  logic        rd_n,
	input  logic        wr_n,
	input  logic        m1_n,
	input  logic        halt_n,
	input  logic        model_zx80,
	input  logic [1:0]  ram_size,
	input  logic        low_ram,
	input  logic        ce_cpu_p,
	input  logic        ce_cpu_n,
	input  logic        ce_pix,
	input  logic        nmi_n,
	input  logic        wait_n,
	input  logic [1:0]  mem_sel,
	input  logic [13:0] rom_addr,
	input  logic [15:0] ram_addr,
	input  logic        disp_hsync,
	input  logic        disp_vsync,
	input  logic        hblank,
	input  logic        vblank,
	output int          check_count,
	output int          error_count
);

	int         cyc;
	int         prev_id;
	int         test_errs;
	int         nmi_low;
	int         vb_high;
	logic       armed;
	logic       ce8;
	logic       cep;
	logic       cen;
	logic       m_zx81;
	logic [1:0] m_sz;
	int         scnt;
	int         dcnt;
	logic       hs;
	logic       latch;
	logic       vs;
	logic       vsy;
	logic       hsq;
	logic [4:0] hist;
	logic       dhs;
	logic       dvs;
	logic       hb;
	logic       vb;
	logic       iow;
	logic       exp_nmi_n;
	logic [31:0] exp_map;

	function automatic string test_name(input int id);
		case (id)
			1: return "clock_enables";
			2: return "nmi_period";
			3: return "nmi_off_zx80_ack";
			4: return "memory_map";
			5: return "vsync_display";
			default: return "idle";
		endcase
	endfunction

	// Rule table returning {mem_sel, rom_addr, ram_addr}
	function automatic logic [31:0] expect_map(input logic [15:0] a, input logic m1,
			input logic mreq, input logic zx81, input logic [1:0] sz, input logic lr);
		logic        low16k;
		logic        is_rom;
		logic        hi;
		logic        lo8;
		logic [1:0]  sel;
		logic [13:0] ra;
		logic [15:0] wa;
		low16k = ~a[15] | ~sz[1];
		is_rom = ~a[14] & ~a[13] & (~a[12] | zx81) & low16k;
		hi     = a[15] & sz[1] & (~a[14] | (m1 & sz[0]));
		lo8    = ~a[14] & a[13] & low16k;
		sel    = mreq ? SEL_NONE : is_rom ? SEL_ROM
			: (a[14] | hi | (lr & lo8)) ? SEL_RAM : SEL_NONE;
		ra     = zx81 ? {1'b0, a[12:0]} : {2'b10, a[11:0]};
		// Size code 0 is 1K, 1 is 16K, 2 is 32K and 3 is 48K
		if (lo8)
			wa = {3'b001, a[12:0]};
		else if (sz == 2'd0)
			wa = {6'b010000, a[9:0]};
		else if (sz == 2'd1 || !a[15] || (sz == 2'd2 && a[14]))
			wa = {2'b01, a[13:0]};
		else if (!a[14])
			wa = {2'b10, a[13:0]};
		else
			wa = {m1, 1'b1, a[13:0]};
		return {sel, ra, wa};
	endfunction

	task automatic compare(input string sig, input logic [31:0] exp, input logic [31:0] act);
		check_count++;
		if (exp !== act) begin
			error_count++;
			test_errs++;
			$display("Error %s %s: expected %h, actual %h", test_name(test_id), sig,
				exp, act);
		end
	endtask

	task automatic report_test(input int id);
		if (id == 2 && nmi_low == 0) begin
			error_count++;
			test_errs++;
			$display("nmi_n never went low while NMI generation was on");
		end
		if (id == 5 && vb_high == 0) begin
			error_count++;
			test_errs++;
			$display("vblank never rose after the keyboard read");
		end
		$display("Test %0d %s: %s (%0d errors)", id, test_name(id),
			(test_errs == 0) ? "passed" : "failed", test_errs);
	endtask

	initial begin
		check_count = 0;
		error_count = 0;
		test_errs   = 0;
		prev_id     = 0;
		armed       = 1'b0;
	end

	// Expected enables counted from the first edge after reset
	assign ce8 = (cyc >= 1) && ((cyc - 1) % 8 == 0);
	assign cep = (cyc >= 1) && ((cyc - 1) % 16 == 0);
	assign cen = (cyc >= 1) && ((cyc - 1) % 16 == 8);
	assign iow = ~iorq_n & ~wr_n;
	assign exp_nmi_n = ~(latch & hs);
	assign exp_map = expect_map(addr, m1_n, mreq_n, m_zx81, m_sz, low_ram);

	always @(posedge clk_sys) begin
		if (test_id != prev_id) begin
			if (prev_id != 0)
				report_test(prev_id);
			prev_id   <= test_id;
			test_errs = 0;
			nmi_low   = 0;
			vb_high   = 0;
		end
		if (!reset && armed) begin
			compare("ce_pix", ce8, ce_pix);
			compare("ce_cpu_p", cep, ce_cpu_p);
			compare("ce_cpu_n", cen, ce_cpu_n);
			compare("nmi_n", exp_nmi_n, nmi_n);
			compare("wait_n", halt_n | exp_nmi_n, wait_n);
			compare("mem_sel", exp_map[31:30], mem_sel);
			compare("rom_addr", exp_map[29:16], rom_addr);
			compare("ram_addr", exp_map[15:0], ram_addr);
			compare("disp_hsync", dhs, disp_hsync);
			compare("disp_vsync", dvs, disp_vsync);
			compare("hblank", hb, hblank);
			compare("vblank", vb, vblank);
			nmi_low = nmi_low + !nmi_n;
			vb_high = vb_high + vblank;
		end
		if (reset) begin
			armed  <= 1'b1;
			cyc    <= 0;
			m_zx81 <= ~model_zx80;
			m_sz   <= ram_size + 2'd1;
			{scnt, dcnt, hs, latch, vs, vsy, hsq, hist, dhs, dvs, hb, vb} <= '0;
		end else begin
			cyc <= cyc + 1;
			// Interrupt acknowledge restarts the bus line
			if (!m1_n && !iorq_n) begin
				scnt <= 0;
				hs   <= 1'b0;
			end else if (cep) begin
				scnt <= (scnt == SYNC_LINE_TICKS - 1) ? 0 : scnt + 1;
				if (scnt == HSYNC_ON_TICK)
					hs <= 1'b1;
				if (scnt == HSYNC_OFF_TICK)
					hs <= 1'b0;
			end
			if (!m_zx81)
				latch <= 1'b0;
			else if (iow && (addr[0] ^ addr[1]))
				latch <= ~addr[1];
			if (!iorq_n && !rd_n && !addr[0] && !latch)
				vs <= 1'b1;
			else if (iow && !latch)
				vs <= 1'b0;
			if (!hs)
				vsy <= vs;
			if (ce8) begin
				dcnt <= (dcnt == DISP_LINE_TICKS - 1) ? 0 : dcnt + 1;
				if (dcnt == 0)
					dhs <= 1'b1;
				if (dcnt == DISP_HSYNC_END)
					dhs <= 1'b0;
				if (dcnt == HBLANK_ON)
					hb <= 1'b1;
				if (dcnt == HBLANK_OFF)
					hb <= 1'b0;
				hsq <= hs;
				if (hs && !hsq) begin
					hist <= {hist[3:0], vsy};
					vb   <= |{hist, vsy};
					dvs  <= hist[2];
					if (hist[3] && hist[2])
						dcnt <= 0;
				end
			end
		end
	end

endmodule

`default_nettype wire

//--- src.f
rtl/zx_ula_pkg.sv
rtl/zx_clock_enables.sv
rtl/zx_sync_control.sv
rtl/zx_display_timing.sv
rtl/zx_memory_map.sv
rtl/zx_ula_top.sv
sim/zx_ula_checker.sv
sim/tb_zx_ula.sv
